// File: common/rv_exec_pkg.sv
/*
 * Execute cluster package
 * Register width and register address width defaults
 * Operation code enumeration
 * Load/store classification helper
 */
package rv_exec_pkg;

  // Integer data path width
  localparam int unsigned XLEN = 32;
  // Register index width, 32 architectural registers
  localparam int unsigned REG_ADDR_WIDTH = 5;

  // Operation codes issued by the host
  typedef enum logic [3:0] {
    OP_ADD    = 4'd0,
    OP_SUB    = 4'd1,
    OP_AND    = 4'd2,
    OP_OR     = 4'd3,
    OP_XOR    = 4'd4,
    OP_SLL    = 4'd5,
    OP_ADDI   = 4'd6,
    OP_LW     = 4'd7,
    OP_LW_PI  = 4'd8,
    OP_SW     = 4'd9,
    OP_SW_PI  = 4'd10
  } exec_op_e;

  // True for any word load or store, with or without post-increment
  function automatic logic is_mem_op(exec_op_e op);
    return op inside {OP_LW, OP_LW_PI, OP_SW, OP_SW_PI};
  endfunction

endpackage

// File: common/rv_mem_pkg.sv
/*
 * Data memory package
 * Word address and word width defaults
 * Byte offset of the word address within a byte address
 */
package rv_mem_pkg;

  // Default depth is 256 words
  localparam int unsigned MEM_ADDR_WIDTH_DEF = 8;

  // One memory word holds one register
  localparam int unsigned MEM_DATA_WIDTH_DEF = 32;

  // Bits [1:0] of a byte address select the byte inside a word
  localparam int unsigned MEM_WORD_OFFSET = 2;

endpackage

// File: regfile/riscv_register_file.sv
/*
 * Three read, two write register file
 * x0 hardwired to zero, write port B wins over port A
 * Combinational read ports
 */
`timescale 1ns/1ps

module riscv_register_file #(
  parameter int unsigned ADDR_WIDTH = rv_exec_pkg::REG_ADDR_WIDTH,
  parameter int unsigned DATA_WIDTH = rv_exec_pkg::XLEN
) (
  input  logic                  clk,
  input  logic                  rst_n,
  // Read ports
  input  logic [ADDR_WIDTH-1:0] raddr_a_i,
  input  logic [ADDR_WIDTH-1:0] raddr_b_i,
  input  logic [ADDR_WIDTH-1:0] raddr_c_i,
  output logic [DATA_WIDTH-1:0] rdata_a_o,
  output logic [DATA_WIDTH-1:0] rdata_b_o,
  output logic [DATA_WIDTH-1:0] rdata_c_o,
  // Write port A, ALU side
  input  logic [ADDR_WIDTH-1:0] waddr_a_i,
  input  logic [DATA_WIDTH-1:0] wdata_a_i,
  input  logic                  we_a_i,
  // Write port B, load side
  input  logic [ADDR_WIDTH-1:0] waddr_b_i,
  input  logic [DATA_WIDTH-1:0] wdata_b_i,
  input  logic                  we_b_i
);

  localparam int unsigned NUM_WORDS = 2**ADDR_WIDTH;

  logic [DATA_WIDTH-1:0] rf_reg [NUM_WORDS];
  logic [NUM_WORDS-1:0]  we_a_dec;
  logic [NUM_WORDS-1:0]  we_b_dec;

  // One-hot write enables per word
  always_comb
  begin
    for (int i = 0; i < NUM_WORDS; i++)
    begin
      we_a_dec[i] = we_a_i && (waddr_a_i == ADDR_WIDTH'(i));
      we_b_dec[i] = we_b_i && (waddr_b_i == ADDR_WIDTH'(i));
    end
  end

  // x0 never stored
  assign rf_reg[0] = '0;

  for (genvar i = 1; i < NUM_WORDS; i++)
  begin : g_word
    always_ff @(posedge clk or negedge rst_n)
    begin
      if (!rst_n)
      begin
        rf_reg[i] <= '0;
      end
      // Port B first so a loaded value beats a post-increment base
      else if (we_b_dec[i])
      begin
        rf_reg[i] <= wdata_b_i;
      end
      else if (we_a_dec[i])
      begin
        rf_reg[i] <= wdata_a_i;
      end
    end
  end

  assign rdata_a_o = rf_reg[raddr_a_i];
  assign rdata_b_o = rf_reg[raddr_b_i];
  assign rdata_c_o = rf_reg[raddr_c_i];

  // Notice when both ports hit one nonzero register and port B data stays
  a_port_b_wins: assert property (@(posedge clk) disable iff (!rst_n)
    !(we_a_i && we_b_i && (waddr_a_i == waddr_b_i) && (waddr_b_i != '0)))
  else
    $info("Write collision on x%0d, port B kept", $sampled(waddr_b_i));

endmodule

// File: logic/alu_unit.sv
/*
 * Integer ALU
 * Register and immediate arithmetic, effective address for loads and stores
 * Drives write port A with the result or the post-increment base
 */
`timescale 1ns/1ps

module alu_unit (
  input  logic                                  op_valid_i,
  input  rv_exec_pkg::exec_op_e                 op_i,
  input  logic [rv_exec_pkg::REG_ADDR_WIDTH-1:0] rd_i,
  input  logic [rv_exec_pkg::REG_ADDR_WIDTH-1:0] rs1_i,
  input  logic [rv_exec_pkg::XLEN-1:0]          imm_i,
  input  logic [rv_exec_pkg::XLEN-1:0]          rs1_data_i,
  input  logic [rv_exec_pkg::XLEN-1:0]          rs2_data_i,
  // Byte address for the load/store unit
  output logic [rv_exec_pkg::XLEN-1:0]          addr_o,
  // Write port A
  output logic                                  we_a_o,
  output logic [rv_exec_pkg::REG_ADDR_WIDTH-1:0] waddr_a_o,
  output logic [rv_exec_pkg::XLEN-1:0]          wdata_a_o
);

  import rv_exec_pkg::*;

  localparam int unsigned SHAMT_WIDTH = $clog2(XLEN);

  logic [XLEN-1:0] base_plus_imm;
  logic            post_inc;

  // Shared adder for ADDI, addresses and post-increment
  assign base_plus_imm = rs1_data_i + imm_i;
  assign addr_o        = base_plus_imm;

  assign post_inc = (op_i == OP_LW_PI) || (op_i == OP_SW_PI);

  always_comb
  begin
    case (op_i)
      OP_ADD:  wdata_a_o = rs1_data_i + rs2_data_i;
      OP_SUB:  wdata_a_o = rs1_data_i - rs2_data_i;
      OP_AND:  wdata_a_o = rs1_data_i & rs2_data_i;
      OP_OR:   wdata_a_o = rs1_data_i | rs2_data_i;
      OP_XOR:  wdata_a_o = rs1_data_i ^ rs2_data_i;
      // Only the low bits of rs2 count as shift amount
      OP_SLL:  wdata_a_o = rs1_data_i << rs2_data_i[SHAMT_WIDTH-1:0];
      default: wdata_a_o = base_plus_imm;
    endcase
  end

  // Plain loads and stores leave the register file alone
  assign we_a_o    = op_valid_i && (!is_mem_op(op_i) || post_inc);
  // Post-increment goes back into the base register
  assign waddr_a_o = post_inc ? rs1_i : rd_i;

  // Host must only send defined opcodes
  always_comb
  begin
    a_known_op: assert final (!op_valid_i || (op_i inside {OP_ADD, OP_SUB, OP_AND,
      OP_OR, OP_XOR, OP_SLL, OP_ADDI, OP_LW, OP_LW_PI, OP_SW, OP_SW_PI}))
    else
      $error("Unknown opcode %0d issued", op_i);
  end

endmodule

// File: logic/lsu_unit.sv
/*
 * Load/store unit
 * Turns word loads and stores into memory requests
 * Tracks one pending load, writes it back through port B, drives busy
 */
`timescale 1ns/1ps

module lsu_unit #(
  parameter int unsigned MEM_ADDR_WIDTH = rv_mem_pkg::MEM_ADDR_WIDTH_DEF
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   op_valid_i,
  input  rv_exec_pkg::exec_op_e                  op_i,
  input  logic [rv_exec_pkg::REG_ADDR_WIDTH-1:0] rd_i,
  input  logic [rv_exec_pkg::XLEN-1:0]           addr_i,
  input  logic [rv_exec_pkg::XLEN-1:0]           store_data_i,
  // Memory request towards the arbiter
  output logic                                   mem_req_o,
  output logic                                   mem_we_o,
  output logic [MEM_ADDR_WIDTH-1:0]              mem_addr_o,
  output logic [rv_mem_pkg::MEM_DATA_WIDTH_DEF-1:0] mem_wdata_o,
  input  logic [rv_mem_pkg::MEM_DATA_WIDTH_DEF-1:0] mem_rdata_i,
  // Write port B
  output logic                                   we_b_o,
  output logic [rv_exec_pkg::REG_ADDR_WIDTH-1:0] waddr_b_o,
  output logic [rv_exec_pkg::XLEN-1:0]           wdata_b_o,
  output logic                                   busy_o
);

  import rv_exec_pkg::*;
  import rv_mem_pkg::*;

  logic                      is_load;
  logic                      is_store;
  logic                      load_pend_q;
  logic [REG_ADDR_WIDTH-1:0] load_rd_q;

  assign is_load  = (op_i == OP_LW) || (op_i == OP_LW_PI);
  assign is_store = (op_i == OP_SW) || (op_i == OP_SW_PI);

  // Request in the issue cycle, arbiter always grants us
  assign mem_req_o   = op_valid_i && is_mem_op(op_i);
  assign mem_we_o    = op_valid_i && is_store;
  // Drop the byte offset, keep the word index
  assign mem_addr_o  = addr_i[MEM_WORD_OFFSET +: MEM_ADDR_WIDTH];
  assign mem_wdata_o = store_data_i;

  // Load in flight for exactly one cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      load_pend_q <= 1'b0;
    end
    else
    begin
      load_pend_q <= op_valid_i && is_load;
    end
  end

  // Destination of the returning load
  always_ff @(posedge clk)
  begin
    if (op_valid_i && is_load)
    begin
      load_rd_q <= rd_i;
    end
  end

  // Memory data lands in rd at the end of the busy cycle
  assign we_b_o    = load_pend_q;
  assign waddr_b_o = load_rd_q;
  assign wdata_b_o = mem_rdata_i;
  assign busy_o    = load_pend_q;

  // Host keeps quiet in the cycle after issuing a load
  a_no_op_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
    (op_valid_i && is_load) |=> !op_valid_i)
  else
    $error("Operation issued while a load is pending");

endmodule

// File: logic/mem_arbiter.sv
/*
 * Fixed-priority data memory arbiter
 * Load/store unit first, host second
 * Steers returning read data to its owner
 */
`timescale 1ns/1ps

module mem_arbiter #(
  parameter int unsigned MEM_ADDR_WIDTH = rv_mem_pkg::MEM_ADDR_WIDTH_DEF
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  // Load/store unit side
  input  logic                                      lsu_req_i,
  input  logic                                      lsu_we_i,
  input  logic [MEM_ADDR_WIDTH-1:0]                 lsu_addr_i,
  input  logic [rv_mem_pkg::MEM_DATA_WIDTH_DEF-1:0] lsu_wdata_i,
  output logic [rv_mem_pkg::MEM_DATA_WIDTH_DEF-1:0] lsu_rdata_o,
  // Host side
  input  logic                                      host_req_i,
  input  logic                                      host_we_i,
  input  logic [MEM_ADDR_WIDTH-1:0]                 host_addr_i,
  input  logic [rv_mem_pkg::MEM_DATA_WIDTH_DEF-1:0] host_wdata_i,
  output logic                                      host_gnt_o,
  output logic [rv_mem_pkg::MEM_DATA_WIDTH_DEF-1:0] host_rdata_o,
  // Merged memory port
  output logic                                      mem_en_o,
  output logic                                      mem_we_o,
  output logic [MEM_ADDR_WIDTH-1:0]                 mem_addr_o,
  output logic [rv_mem_pkg::MEM_DATA_WIDTH_DEF-1:0] mem_wdata_o,
  input  logic [rv_mem_pkg::MEM_DATA_WIDTH_DEF-1:0] mem_rdata_i
);

  logic lsu_rd_q;
  logic host_rd_q;

  // Host only wins an idle cycle
  assign host_gnt_o = host_req_i && !lsu_req_i;

  assign mem_en_o    = lsu_req_i || host_req_i;
  assign mem_we_o    = lsu_req_i ? lsu_we_i    : host_we_i;
  assign mem_addr_o  = lsu_req_i ? lsu_addr_i  : host_addr_i;
  assign mem_wdata_o = lsu_req_i ? lsu_wdata_i : host_wdata_i;

  // Owner of the read data arriving next cycle
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      lsu_rd_q  <= 1'b0;
      host_rd_q <= 1'b0;
    end
    else
    begin
      lsu_rd_q  <= lsu_req_i && !lsu_we_i;
      host_rd_q <= host_gnt_o && !host_we_i;
    end
  end

  // Each side sees only its own read data
  assign lsu_rdata_o  = lsu_rd_q  ? mem_rdata_i : '0;
  assign host_rdata_o = host_rd_q ? mem_rdata_i : '0;

  a_single_owner: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({lsu_rd_q, host_rd_q}))
  else
    $error("Read data claimed by both requesters");

endmodule

// File: logic/data_mem.sv
/*
 * Single-port synchronous data memory
 * Write at the clock edge, registered read data
 */
`timescale 1ns/1ps

module data_mem #(
  parameter int unsigned MEM_ADDR_WIDTH = rv_mem_pkg::MEM_ADDR_WIDTH_DEF
) (
  input  logic                                      clk,
  input  logic                                      en_i,
  input  logic                                      we_i,
  input  logic [MEM_ADDR_WIDTH-1:0]                 addr_i,
  input  logic [rv_mem_pkg::MEM_DATA_WIDTH_DEF-1:0] wdata_i,
  output logic [rv_mem_pkg::MEM_DATA_WIDTH_DEF-1:0] rdata_o
);

  import rv_mem_pkg::*;

  localparam int unsigned DEPTH = 2**MEM_ADDR_WIDTH;

  logic [MEM_DATA_WIDTH_DEF-1:0] mem [DEPTH];

  // One access per cycle, read data valid a cycle later
  always_ff @(posedge clk)
  begin
    if (en_i)
    begin
      if (we_i)
      begin
        mem[addr_i] <= wdata_i;
      end
      else
      begin
        rdata_o <= mem[addr_i];
      end
    end
  end

endmodule

// File: logic/exec_cluster.sv
/*
 * Execute cluster top level
 * Register file, ALU, load/store unit, memory arbiter and data memory
 */
`timescale 1ns/1ps

module exec_cluster #(
  parameter int unsigned MEM_ADDR_WIDTH = rv_mem_pkg::MEM_ADDR_WIDTH_DEF
) (
  input  logic                                      clk,
  input  logic                                      rst_n,
  // Operation issue
  input  logic                                      op_valid_i,
  input  rv_exec_pkg::exec_op_e                     op_i,
  input  logic [rv_exec_pkg::REG_ADDR_WIDTH-1:0]    rd_i,
  input  logic [rv_exec_pkg::REG_ADDR_WIDTH-1:0]    rs1_i,
  input  logic [rv_exec_pkg::REG_ADDR_WIDTH-1:0]    rs2_i,
  input  logic [rv_exec_pkg::XLEN-1:0]              imm_i,
  output logic                                      busy_o,
  // Debug read through port C
  input  logic [rv_exec_pkg::REG_ADDR_WIDTH-1:0]    dbg_raddr_i,
  output logic [rv_exec_pkg::XLEN-1:0]              dbg_rdata_o,
  // Host memory port
  input  logic                                      host_req_i,
  input  logic                                      host_we_i,
  input  logic [MEM_ADDR_WIDTH-1:0]                 host_addr_i,
  input  logic [rv_mem_pkg::MEM_DATA_WIDTH_DEF-1:0] host_wdata_i,
  output logic                                      host_gnt_o,
  output logic [rv_mem_pkg::MEM_DATA_WIDTH_DEF-1:0] host_rdata_o
);

  import rv_exec_pkg::*;
  import rv_mem_pkg::*;

  // Register read data
  logic [XLEN-1:0]               rs1_data;
  logic [XLEN-1:0]               rs2_data;
  // Write ports
  logic                          we_a;
  logic [REG_ADDR_WIDTH-1:0]     waddr_a;
  logic [XLEN-1:0]               wdata_a;
  logic                          we_b;
  logic [REG_ADDR_WIDTH-1:0]     waddr_b;
  logic [XLEN-1:0]               wdata_b;
  // ALU to load/store unit
  logic [XLEN-1:0]               eff_addr;
  // Load/store unit to arbiter
  logic                          lsu_req;
  logic                          lsu_we;
  logic [MEM_ADDR_WIDTH-1:0]     lsu_addr;
  logic [MEM_DATA_WIDTH_DEF-1:0] lsu_wdata;
  logic [MEM_DATA_WIDTH_DEF-1:0] lsu_rdata;
  // Arbiter to memory
  logic                          mem_en;
  logic                          mem_we;
  logic [MEM_ADDR_WIDTH-1:0]     mem_addr;
  logic [MEM_DATA_WIDTH_DEF-1:0] mem_wdata;
  logic [MEM_DATA_WIDTH_DEF-1:0] mem_rdata;

  riscv_register_file #(
    .ADDR_WIDTH (REG_ADDR_WIDTH),
    .DATA_WIDTH (XLEN)
  ) u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (rs1_i),
    .raddr_b_i (rs2_i),
    .raddr_c_i (dbg_raddr_i),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data),
    .rdata_c_o (dbg_rdata_o),
    .waddr_a_i (waddr_a),
    .wdata_a_i (wdata_a),
    .we_a_i    (we_a),
    .waddr_b_i (waddr_b),
    .wdata_b_i (wdata_b),
    .we_b_i    (we_b)
  );

  alu_unit u_alu (
    .op_valid_i (op_valid_i),
    .op_i       (op_i),
    .rd_i       (rd_i),
    .rs1_i      (rs1_i),
    .imm_i      (imm_i),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .addr_o     (eff_addr),
    .we_a_o     (we_a),
    .waddr_a_o  (waddr_a),
    .wdata_a_o  (wdata_a)
  );

  // Store data comes straight from rs2
  lsu_unit #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_lsu (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_valid_i   (op_valid_i),
    .op_i         (op_i),
    .rd_i         (rd_i),
    .addr_i       (eff_addr),
    .store_data_i (rs2_data),
    .mem_req_o    (lsu_req),
    .mem_we_o     (lsu_we),
    .mem_addr_o   (lsu_addr),
    .mem_wdata_o  (lsu_wdata),
    .mem_rdata_i  (lsu_rdata),
    .we_b_o       (we_b),
    .waddr_b_o    (waddr_b),
    .wdata_b_o    (wdata_b),
    .busy_o       (busy_o)
  );

  mem_arbiter #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_arbiter (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req_i    (lsu_req),
    .lsu_we_i     (lsu_we),
    .lsu_addr_i   (lsu_addr),
    .lsu_wdata_i  (lsu_wdata),
    .lsu_rdata_o  (lsu_rdata),
    .host_req_i   (host_req_i),
    .host_we_i    (host_we_i),
    .host_addr_i  (host_addr_i),
    .host_wdata_i (host_wdata_i),
    .host_gnt_o   (host_gnt_o),
    .host_rdata_o (host_rdata_o),
    .mem_en_o     (mem_en),
    .mem_we_o     (mem_we),
    .mem_addr_o   (mem_addr),
    .mem_wdata_o  (mem_wdata),
    .mem_rdata_i  (mem_rdata)
  );

  data_mem #(
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) u_mem (
    .clk     (clk),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

// File: test/exec_checker.sv
/*
 * Testbench checker for the execute cluster
 * Compares DUT outputs with the expected values sent by the testbench
 * Prints failing checks, one line per test and a closing count line
 */
`timescale 1ns/1ps

module exec_checker (
  input  logic                         clk,
  // Expected value from the testbench
  input  logic                         chk_en_i,
  input  logic [1:0]                   chk_sel_i,
  input  logic [rv_exec_pkg::XLEN-1:0] chk_exp_i,
  input  int unsigned                  test_id_i,
  input  logic                         test_done_i,
  input  logic                         run_done_i,
  // Watched DUT outputs
  input  logic [rv_exec_pkg::XLEN-1:0] dbg_rdata_i,
  input  logic [rv_exec_pkg::XLEN-1:0] host_rdata_i,
  input  logic                         busy_i,
  input  logic                         host_gnt_i,
  output int unsigned                  error_count_o
);

  import rv_exec_pkg::*;

  // Which DUT output a check looks at
  localparam logic [1:0] SEL_DBG  = 2'd0;
  localparam logic [1:0] SEL_HOST = 2'd1;
  localparam logic [1:0] SEL_BUSY = 2'd2;
  localparam logic [1:0] SEL_GNT  = 2'd3;

  logic [XLEN-1:0] actual;
  int unsigned     test_checks = 0;
  int unsigned     test_errors = 0;
  int unsigned     total_checks = 0;
  int unsigned     total_errors = 0;
  int unsigned     tests_run = 0;

  assign error_count_o = total_errors;

  function automatic string test_label(int unsigned id);
    case (id)
      0:       return "reset_state";
      1:       return "alu_ops";
      2:       return "store_load";
      3:       return "post_increment";
      4:       return "host_contention";
      default: return "unknown";
    endcase
  endfunction

  function automatic string sel_label(logic [1:0] sel);
    case (sel)
      SEL_DBG:  return "dbg_rdata";
      SEL_HOST: return "host_rdata";
      SEL_BUSY: return "busy";
      default:  return "host_gnt";
    endcase
  endfunction

  // Selected output, single bits zero extended
  always_comb
  begin
    case (chk_sel_i)
      SEL_DBG:  actual = dbg_rdata_i;
      SEL_HOST: actual = host_rdata_i;
      SEL_BUSY: actual = XLEN'(busy_i);
      default:  actual = XLEN'(host_gnt_i);
    endcase
  end

  // Mid-cycle sampling, inputs change just after the rising edge
  always @(negedge clk)
  begin
    if (chk_en_i)
    begin
      test_checks++;
      total_checks++;
      // X or Z counts as a mismatch
      if (actual !== chk_exp_i)
      begin
        test_errors++;
        total_errors++;
        $display("Fail %0s: %0s expected %h actual %h", test_label(test_id_i),
          sel_label(chk_sel_i), chk_exp_i, actual);
      end
    end
    if (test_done_i)
    begin
      tests_run++;
      $display("Test %0s done: %0d checks, %0d errors", test_label(test_id_i),
        test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
    if (run_done_i)
    begin
      $display("Tests %0d, checks %0d, errors %0d", tests_run, total_checks, total_errors);
    end
  end

endmodule

// File: test/tb_exec_cluster.sv
/*
 * Testbench top for the execute cluster
 * Clock, reset, stimulus and timeout
 * Reference model of registers and data memory, DUT and checker instances
 */
`timescale 1ns/1ps

module tb_exec_cluster;

  import rv_exec_pkg::*;

  localparam int unsigned MEM_AW    = 8;
  localparam int unsigned NUM_WORDS = 2**MEM_AW;
  localparam int unsigned NUM_ALU   = 150;
  localparam int unsigned NUM_LDST  = 20;
  localparam int unsigned NUM_PI    = 20;
  localparam int unsigned NUM_HOST  = 10;
  // Cycles per step of each test, doubled for margin
  localparam int unsigned MAX_CYCLES = 2 * (50 + NUM_WORDS + 2 * NUM_ALU + 6 * NUM_LDST
    + 6 * NUM_PI + 4 * NUM_HOST);

  localparam logic [1:0] SEL_DBG  = 2'd0;
  localparam logic [1:0] SEL_HOST = 2'd1;
  localparam logic [1:0] SEL_BUSY = 2'd2;
  localparam logic [1:0] SEL_GNT  = 2'd3;

  logic                clk;
  logic                rst_n;
  logic                op_valid;
  exec_op_e            op;
  logic [4:0]          rd;
  logic [4:0]          rs1;
  logic [4:0]          rs2;
  logic [XLEN-1:0]     imm;
  logic                busy;
  logic [4:0]          dbg_raddr;
  logic [XLEN-1:0]     dbg_rdata;
  logic                host_req;
  logic                host_we;
  logic [MEM_AW-1:0]   host_addr;
  logic [XLEN-1:0]     host_wdata;
  logic                host_gnt;
  logic [XLEN-1:0]     host_rdata;
  // Checker interface
  logic                chk_en;
  logic [1:0]          chk_sel;
  logic [XLEN-1:0]     chk_exp;
  int unsigned         test_id;
  logic                test_done;
  logic                run_done;
  int unsigned         error_count;
  int unsigned         cycle_count;
  // Reference state
  logic [XLEN-1:0]     ref_regs [32];
  logic [XLEN-1:0]     ref_mem [NUM_WORDS];

  initial clk = 1'b0;
  always #5 clk = ~clk;

  exec_cluster #(
    .MEM_ADDR_WIDTH (MEM_AW)
  ) DUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_valid_i   (op_valid),
    .op_i         (op),
    .rd_i         (rd),
    .rs1_i        (rs1),
    .rs2_i        (rs2),
    .imm_i        (imm),
    .busy_o       (busy),
    .dbg_raddr_i  (dbg_raddr),
    .dbg_rdata_o  (dbg_rdata),
    .host_req_i   (host_req),
    .host_we_i    (host_we),
    .host_addr_i  (host_addr),
    .host_wdata_i (host_wdata),
    .host_gnt_o   (host_gnt),
    .host_rdata_o (host_rdata)
  );

  exec_checker u_checker (
    .clk           (clk),
    .chk_en_i      (chk_en),
    .chk_sel_i     (chk_sel),
    .chk_exp_i     (chk_exp),
    .test_id_i     (test_id),
    .test_done_i   (test_done),
    .run_done_i    (run_done),
    .dbg_rdata_i   (dbg_rdata),
    .host_rdata_i  (host_rdata),
    .busy_i        (busy),
    .host_gnt_i    (host_gnt),
    .error_count_o (error_count)
  );

  // RV32 integer semantics, shift amount from rs2[4:0]
  function automatic logic [XLEN-1:0] predict_alu(exec_op_e code, logic [XLEN-1:0] a,
    logic [XLEN-1:0] b, logic [XLEN-1:0] k);
    case (code)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[4:0];
      default: return a + k;
    endcase
  endfunction

  // Every byte depends on the full word index
  function automatic logic [XLEN-1:0] fill_word(logic [MEM_AW-1:0] w);
    return (32'(w) * 32'h0101_0101) ^ 32'h5A3C_96E1;
  endfunction

  // x0 ignores writes
  task automatic model_write(logic [4:0] idx, logic [XLEN-1:0] val);
    if (idx != 5'd0)
    begin
      ref_regs[idx] = val;
    end
  endtask

  task automatic model_op(exec_op_e code, logic [4:0] d, logic [4:0] s1, logic [4:0] s2,
    logic [XLEN-1:0] k);
    logic [XLEN-1:0]   a;
    logic [XLEN-1:0]   b;
    logic [XLEN-1:0]   sum;
    logic [MEM_AW-1:0] widx;
    a    = ref_regs[s1];
    b    = ref_regs[s2];
    sum  = a + k;
    widx = sum[2 +: MEM_AW];
    case (code)
      OP_LW:   model_write(d, ref_mem[widx]);
      // Loaded word lands after the base update and so wins
      OP_LW_PI:
      begin
        model_write(s1, sum);
        model_write(d, ref_mem[widx]);
      end
      OP_SW:   ref_mem[widx] = b;
      OP_SW_PI:
      begin
        ref_mem[widx] = b;
        model_write(s1, sum);
      end
      default: model_write(d, predict_alu(code, a, b, k));
    endcase
  endtask

  // Advance one cycle, drop one-cycle strobes
  task automatic step();
    @(posedge clk);
    #1;
    chk_en    = 1'b0;
    test_done = 1'b0;
  endtask

  task automatic expect_value(logic [1:0] sel, logic [XLEN-1:0] exp);
    chk_en  = 1'b1;
    chk_sel = sel;
    chk_exp = exp;
  endtask

  task automatic drive_op(exec_op_e code, logic [4:0] d, logic [4:0] s1, logic [4:0] s2,
    logic [XLEN-1:0] k);
    model_op(code, d, s1, s2, k);
    op_valid = 1'b1;
    op       = code;
    rd       = d;
    rs1      = s1;
    rs2      = s2;
    imm      = k;
  endtask

  // Issue cycle, a load then holds busy for the next cycle
  task automatic issue_op(exec_op_e code, logic [4:0] d, logic [4:0] s1, logic [4:0] s2,
    logic [XLEN-1:0] k);
    drive_op(code, d, s1, s2, k);
    step();
    op_valid = 1'b0;
    if ((code == OP_LW) || (code == OP_LW_PI))
    begin
      expect_value(SEL_BUSY, XLEN'(1));
      step();
    end
    while (busy)
    begin
      step();
    end
  endtask

  task automatic check_reg(logic [4:0] idx);
    dbg_raddr = idx;
    expect_value(SEL_DBG, ref_regs[idx]);
    step();
  endtask

  // Hold the request until the grant, read data one cycle later
  task automatic host_access(logic we, logic [MEM_AW-1:0] addr, logic [XLEN-1:0] wdata);
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = addr;
    host_wdata = wdata;
    @(negedge clk);
    while (!host_gnt)
    begin
      @(negedge clk);
    end
    step();
    host_req = 1'b0;
    if (we)
    begin
      ref_mem[addr] = wdata;
    end
    else
    begin
      expect_value(SEL_HOST, ref_mem[addr]);
      step();
    end
  endtask

  task automatic finish_test();
    test_done = 1'b1;
    step();
  endtask

  initial
  begin
    logic [4:0]        d;
    logic [4:0]        s1;
    logic [4:0]        s2;
    logic [XLEN-1:0]   k;
    logic [XLEN-1:0]   sum;
    logic [MEM_AW-1:0] widx;
    exec_op_e          code;
    void'($urandom(39));
    rst_n      = 1'b0;
    op_valid   = 1'b0;
    op         = OP_ADD;
    rd         = '0;
    rs1        = '0;
    rs2        = '0;
    imm        = '0;
    dbg_raddr  = '0;
    host_req   = 1'b0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    chk_en     = 1'b0;
    chk_sel    = SEL_DBG;
    chk_exp    = '0;
    test_id    = 0;
    test_done  = 1'b0;
    run_done   = 1'b0;
    for (int i = 0; i < 32; i++)
    begin
      ref_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Reset state
    test_id = 0;
    for (int i = 0; i < 32; i++)
    begin
      check_reg(5'(i));
    end
    expect_value(SEL_BUSY, '0);
    step();
    expect_value(SEL_GNT, '0);
    step();
    finish_test();

    // Known contents everywhere before any load
    for (int w = 0; w < NUM_WORDS; w++)
    begin
      host_access(1'b1, MEM_AW'(w), fill_word(MEM_AW'(w)));
    end

    // Random ALU and ADDI, every tenth one aimed at x0
    test_id = 1;
    for (int i = 0; i < NUM_ALU; i++)
    begin
      code = exec_op_e'($urandom_range(6, 0));
      d    = (i % 10 == 0) ? 5'd0 : 5'($urandom_range(31, 0));
      issue_op(code, d, 5'($urandom_range(31, 0)), 5'($urandom_range(31, 0)), $urandom);
      check_reg(d);
    end
    finish_test();

    // Store, load back from the same word, then read it through the host
    test_id = 2;
    for (int i = 0; i < NUM_LDST; i++)
    begin
      s1   = 5'($urandom_range(31, 1));
      s2   = 5'($urandom_range(31, 0));
      d    = 5'($urandom_range(31, 0));
      k    = $urandom;
      sum  = ref_regs[s1] + k;
      widx = sum[2 +: MEM_AW];
      issue_op(OP_SW, 5'd0, s1, s2, k);
      issue_op(OP_LW, d, s1, 5'd0, k);
      check_reg(d);
      host_access(1'b0, widx, '0);
    end
    finish_test();

    // Post-increment, every fourth load has rd equal to rs1
    test_id = 3;
    for (int i = 0; i < NUM_PI; i++)
    begin
      s1 = 5'($urandom_range(31, 1));
      d  = (i % 4 == 0) ? s1 : 5'($urandom_range(31, 0));
      k  = XLEN'($urandom_range(64, 0) * 4);
      issue_op(OP_SW_PI, 5'd0, s1, 5'($urandom_range(31, 0)), k);
      check_reg(s1);
      issue_op(OP_LW_PI, d, s1, 5'd0, k);
      check_reg(s1);
      check_reg(d);
    end
    finish_test();

    // Host read raised together with a load or store
    test_id = 4;
    for (int i = 0; i < NUM_HOST; i++)
    begin
      code = (i % 2 == 1) ? OP_SW : OP_LW;
      s1   = 5'($urandom_range(31, 1));
      d    = 5'($urandom_range(31, 0));
      k    = $urandom;
      sum  = ref_regs[s1] + k;
      // Stores are read back through the host right away
      widx = (code == OP_SW) ? sum[2 +: MEM_AW] : MEM_AW'($urandom);
      drive_op(code, d, s1, 5'($urandom_range(31, 0)), k);
      host_req  = 1'b1;
      host_we   = 1'b0;
      host_addr = widx;
      expect_value(SEL_GNT, '0);
      step();
      op_valid = 1'b0;
      expect_value(SEL_GNT, XLEN'(1));
      step();
      host_req = 1'b0;
      expect_value(SEL_HOST, ref_mem[widx]);
      step();
      if (code == OP_LW)
      begin
        check_reg(d);
      end
    end
    finish_test();

    run_done = 1'b1;
    step();
    if (error_count == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Run limit
  initial
  begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run stopped after %0d cycles", cycle_count);
    $display("Result: FAILED");
    $finish;
  end

endmodule

// File: exec_cluster.f
common/rv_exec_pkg.sv
common/rv_mem_pkg.sv
regfile/riscv_register_file.sv
logic/alu_unit.sv
logic/lsu_unit.sv
logic/mem_arbiter.sv
logic/data_mem.sv
logic/exec_cluster.sv
test/exec_checker.sv
test/tb_exec_cluster.sv

// File: Bender.yml
package:
  name: exec_cluster

sources:
  - common/rv_exec_pkg.sv
  - common/rv_mem_pkg.sv
  - regfile/riscv_register_file.sv
  - logic/alu_unit.sv
  - logic/lsu_unit.sv
  - logic/mem_arbiter.sv
  - logic/data_mem.sv
  - logic/exec_cluster.sv
  - target: test
    files:
      - test/exec_checker.sv
      - test/tb_exec_cluster.sv
